//--- hw/exu_types_pkg.sv
package exu_types_pkg;

    // integer datapath width
    localparam int unsigned XLEN = 64;

    // low half seen by the word ops
    localparam int unsigned WORD_LEN = 32;

    // general registers, x0 included
    localparam int unsigned NUM_GPR = 32;

    // operands, results, register contents
    typedef logic [XLEN-1:0] xlen_t;

    // word op view of a value
    typedef logic [WORD_LEN-1:0] word_t;

    // program counter, same width as data
    typedef logic [XLEN-1:0] pc_t;

    // rd / rs1 / rs2
    typedef logic [$clog2(NUM_GPR)-1:0] reg_idx_t;

endpackage

//--- hw/exu_op_pkg.sv
package exu_op_pkg;

    // issued operation, one code per kept instruction
    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        // word forms, result sign-extended from bit 31
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        // upper immediates
        OP_LUI, OP_AUIPC,
        // jumps write the link value
        OP_JAL, OP_JALR,
        // conditional branches
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
    } exu_op_t;

    // function performed by the ALU in execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_mode_t;

    // how the next pc is formed
    typedef enum logic [3:0] {
        FLOW_SEQ,
        FLOW_JAL,
        FLOW_JALR,
        FLOW_BEQ,
        FLOW_BNE,
        FLOW_BLT,
        FLOW_BGE,
        FLOW_BLTU,
        FLOW_BGEU
    } flow_t;

    // fixed 32-bit instruction size, no compressed forms
    localparam exu_types_pkg::pc_t PC_STEP = 64'd4;

endpackage

//--- hw/exu_issue_if.sv
`timescale 1ns/1ps

interface exu_issue_if;

    // one decoded instruction between pipeline parts
    logic                     valid;
    exu_op_pkg::alu_mode_t    mode;
    exu_op_pkg::flow_t        flow;
    // sign-extend low 32 bits of the ALU result
    logic                     word_op;
    // register write request, x0 filtered at the register file
    logic                     wen;
    exu_types_pkg::reg_idx_t  rd;
    exu_types_pkg::xlen_t     opa;
    exu_types_pkg::xlen_t     opb;
    exu_types_pkg::pc_t       pc;
    // pc + imm, taken branch destination
    exu_types_pkg::pc_t       target;

    // driving side
    modport src (
        output valid, mode, flow, word_op, wen, rd, opa, opb, pc, target
    );

    // receiving side
    modport dst (
        input valid, mode, flow, word_op, wen, rd, opa, opb, pc, target
    );

endinterface

//--- hw/exu_operand_fetch.sv
`timescale 1ns/1ps

module exu_operand_fetch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  exu_op_pkg::exu_op_t     in_op,
    input  logic                    in_use_imm,
    input  exu_types_pkg::reg_idx_t in_rd,
    input  exu_types_pkg::reg_idx_t in_rs1,
    input  exu_types_pkg::reg_idx_t in_rs2,
    input  exu_types_pkg::xlen_t    in_imm,
    input  exu_types_pkg::pc_t      in_pc,
    input  logic                    wb_en,
    input  exu_types_pkg::reg_idx_t wb_rd,
    input  exu_types_pkg::xlen_t    wb_data,
    exu_issue_if.src                fetch_q
);

    exu_types_pkg::xlen_t  gpr [exu_types_pkg::NUM_GPR];
    exu_types_pkg::xlen_t  rs1_val;
    exu_types_pkg::xlen_t  rs2_val;
    exu_types_pkg::word_t  rs1_lo;
    exu_types_pkg::xlen_t  b_src;
    exu_op_pkg::alu_mode_t mode;
    exu_op_pkg::flow_t     flow;
    logic                  word_op;
    logic                  alu_class;
    logic                  imm_op;
    logic                  take_imm;
    logic                  is_shift;

    // register file, x0 never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpr <= '{default: '0};
        end else if (wb_en && wb_rd != '0) begin
            gpr[wb_rd] <= wb_data;
        end
    end

    // reads, x0 forced to zero
    // write in the same cycle wins over the stored value
    assign rs1_val = (in_rs1 == '0) ? '0 :
                     (wb_en && wb_rd == in_rs1) ? wb_data : gpr[in_rs1];
    assign rs2_val = (in_rs2 == '0) ? '0 :
                     (wb_en && wb_rd == in_rs2) ? wb_data : gpr[in_rs2];
    assign rs1_lo  = rs1_val[exu_types_pkg::WORD_LEN-1:0];

    // ALU function, branches compare through sub / slt / sltu
    always_comb begin
        case (in_op)
            exu_op_pkg::OP_SUB, exu_op_pkg::OP_SUBW,
            exu_op_pkg::OP_BEQ, exu_op_pkg::OP_BNE:   mode = exu_op_pkg::ALU_SUB;
            exu_op_pkg::OP_SLL, exu_op_pkg::OP_SLLW:  mode = exu_op_pkg::ALU_SLL;
            exu_op_pkg::OP_SLT, exu_op_pkg::OP_BLT,
            exu_op_pkg::OP_BGE:                       mode = exu_op_pkg::ALU_SLT;
            exu_op_pkg::OP_SLTU, exu_op_pkg::OP_BLTU,
            exu_op_pkg::OP_BGEU:                      mode = exu_op_pkg::ALU_SLTU;
            exu_op_pkg::OP_XOR:                       mode = exu_op_pkg::ALU_XOR;
            exu_op_pkg::OP_SRL, exu_op_pkg::OP_SRLW:  mode = exu_op_pkg::ALU_SRL;
            exu_op_pkg::OP_SRA, exu_op_pkg::OP_SRAW:  mode = exu_op_pkg::ALU_SRA;
            exu_op_pkg::OP_OR:                        mode = exu_op_pkg::ALU_OR;
            exu_op_pkg::OP_AND:                       mode = exu_op_pkg::ALU_AND;
            // add, addw, lui, auipc, jal, jalr
            default:                                  mode = exu_op_pkg::ALU_ADD;
        endcase
    end

    // control flow kind
    always_comb begin
        case (in_op)
            exu_op_pkg::OP_JAL:  flow = exu_op_pkg::FLOW_JAL;
            exu_op_pkg::OP_JALR: flow = exu_op_pkg::FLOW_JALR;
            exu_op_pkg::OP_BEQ:  flow = exu_op_pkg::FLOW_BEQ;
            exu_op_pkg::OP_BNE:  flow = exu_op_pkg::FLOW_BNE;
            exu_op_pkg::OP_BLT:  flow = exu_op_pkg::FLOW_BLT;
            exu_op_pkg::OP_BGE:  flow = exu_op_pkg::FLOW_BGE;
            exu_op_pkg::OP_BLTU: flow = exu_op_pkg::FLOW_BLTU;
            exu_op_pkg::OP_BGEU: flow = exu_op_pkg::FLOW_BGEU;
            default:             flow = exu_op_pkg::FLOW_SEQ;
        endcase
    end

    assign word_op = in_op inside {exu_op_pkg::OP_ADDW, exu_op_pkg::OP_SUBW,
                                   exu_op_pkg::OP_SLLW, exu_op_pkg::OP_SRLW,
                                   exu_op_pkg::OP_SRAW};
    // plain ALU ops, the only ones that honour in_use_imm
    assign alu_class = (flow == exu_op_pkg::FLOW_SEQ) &&
                       !(in_op inside {exu_op_pkg::OP_LUI, exu_op_pkg::OP_AUIPC});
    // always take the immediate as operand b
    assign imm_op    = in_op inside {exu_op_pkg::OP_LUI, exu_op_pkg::OP_AUIPC,
                                     exu_op_pkg::OP_JAL, exu_op_pkg::OP_JALR};
    assign take_imm  = imm_op || (alu_class && in_use_imm);
    assign is_shift  = mode inside {exu_op_pkg::ALU_SLL, exu_op_pkg::ALU_SRL,
                                    exu_op_pkg::ALU_SRA};
    assign b_src     = take_imm ? in_imm : rs2_val;

    // operand a
    always_comb begin
        case (in_op)
            exu_op_pkg::OP_AUIPC, exu_op_pkg::OP_JAL: fetch_q.opa = in_pc;
            exu_op_pkg::OP_LUI:  fetch_q.opa = '0;
            // zero upper half so srl shifts in zeros
            exu_op_pkg::OP_SRLW: fetch_q.opa = exu_types_pkg::xlen_t'(rs1_lo);
            // sign copies in the upper half feed sra
            exu_op_pkg::OP_SRAW: fetch_q.opa = {{(exu_types_pkg::XLEN -
                                                  exu_types_pkg::WORD_LEN)
                                                 {rs1_lo[exu_types_pkg::WORD_LEN-1]}},
                                                rs1_lo};
            default:             fetch_q.opa = rs1_val;
        endcase
    end

    // operand b, shift amount masked to 5 bits for word shifts, 6 otherwise
    always_comb begin
        if (is_shift && word_op) begin
            fetch_q.opb = exu_types_pkg::xlen_t'(b_src[4:0]);
        end else if (is_shift) begin
            fetch_q.opb = exu_types_pkg::xlen_t'(b_src[5:0]);
        end else begin
            fetch_q.opb = b_src;
        end
    end

    assign fetch_q.valid   = in_valid;
    assign fetch_q.mode    = mode;
    assign fetch_q.flow    = flow;
    assign fetch_q.word_op = word_op;
    // branches are the only ops without a result
    assign fetch_q.wen     = alu_class || imm_op;
    assign fetch_q.rd      = in_rd;
    assign fetch_q.pc      = in_pc;
    assign fetch_q.target  = in_pc + in_imm;

endmodule

//--- hw/exu_issue_buffer.sv
`timescale 1ns/1ps

module exu_issue_buffer (
    input  logic     clk,
    input  logic     rst_n,
    exu_issue_if.dst fetch_q,
    exu_issue_if.src exec_q
);

    // issue strobe, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exec_q.valid <= 1'b0;
        end else begin
            exec_q.valid <= fetch_q.valid;
        end
    end

    // payload, loaded every cycle
    // don't care while valid is low
    always_ff @(posedge clk) begin
        exec_q.mode    <= fetch_q.mode;
        exec_q.flow    <= fetch_q.flow;
        exec_q.word_op <= fetch_q.word_op;
        exec_q.wen     <= fetch_q.wen;
        exec_q.rd      <= fetch_q.rd;
        exec_q.opa     <= fetch_q.opa;
        exec_q.opb     <= fetch_q.opb;
        exec_q.pc      <= fetch_q.pc;
        exec_q.target  <= fetch_q.target;
    end

endmodule

//--- hw/exu_execute.sv
`timescale 1ns/1ps

module exu_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    exu_issue_if.dst                exec_q,
    output logic                    wb_en,
    output exu_types_pkg::reg_idx_t wb_rd,
    output exu_types_pkg::xlen_t    wb_data,
    output logic                    out_valid,
    output exu_types_pkg::pc_t      out_pc,
    output exu_types_pkg::pc_t      out_dnpc,
    output logic                    out_wen,
    output exu_types_pkg::reg_idx_t out_rd,
    output exu_types_pkg::xlen_t    out_data
);

    logic [$clog2(exu_types_pkg::XLEN)-1:0] shamt;
    exu_types_pkg::xlen_t alu_raw;
    exu_types_pkg::word_t alu_lo;
    exu_types_pkg::xlen_t alu_res;
    exu_types_pkg::xlen_t wdata;
    exu_types_pkg::pc_t   snpc;
    exu_types_pkg::pc_t   dnpc;
    logic                 is_link;

    // opb already masked in fetch
    assign shamt = exec_q.opb[$clog2(exu_types_pkg::XLEN)-1:0];

    always_comb begin
        case (exec_q.mode)
            exu_op_pkg::ALU_ADD:  alu_raw = exec_q.opa + exec_q.opb;
            exu_op_pkg::ALU_SUB:  alu_raw = exec_q.opa - exec_q.opb;
            exu_op_pkg::ALU_SLL:  alu_raw = exec_q.opa << shamt;
            exu_op_pkg::ALU_SLT:  alu_raw = exu_types_pkg::xlen_t'(
                                      $signed(exec_q.opa) < $signed(exec_q.opb));
            exu_op_pkg::ALU_SLTU: alu_raw = exu_types_pkg::xlen_t'(exec_q.opa < exec_q.opb);
            exu_op_pkg::ALU_XOR:  alu_raw = exec_q.opa ^ exec_q.opb;
            exu_op_pkg::ALU_SRL:  alu_raw = exec_q.opa >> shamt;
            exu_op_pkg::ALU_SRA:  alu_raw = $signed(exec_q.opa) >>> shamt;
            exu_op_pkg::ALU_OR:   alu_raw = exec_q.opa | exec_q.opb;
            exu_op_pkg::ALU_AND:  alu_raw = exec_q.opa & exec_q.opb;
            default:              alu_raw = '0;
        endcase
    end

    // word ops keep bit 31 as the sign of the whole result
    assign alu_lo  = alu_raw[exu_types_pkg::WORD_LEN-1:0];
    assign alu_res = exec_q.word_op ?
                     {{(exu_types_pkg::XLEN - exu_types_pkg::WORD_LEN)
                       {alu_lo[exu_types_pkg::WORD_LEN-1]}}, alu_lo} :
                     alu_raw;

    assign snpc    = exec_q.pc + exu_op_pkg::PC_STEP;
    assign is_link = exec_q.flow inside {exu_op_pkg::FLOW_JAL, exu_op_pkg::FLOW_JALR};
    // jumps write the return address
    assign wdata   = is_link ? snpc : alu_res;

    // next pc
    // blt/bltu take on a set slt result, bge/bgeu on a clear one
    always_comb begin
        case (exec_q.flow)
            exu_op_pkg::FLOW_JAL:  dnpc = alu_res;
            exu_op_pkg::FLOW_JALR: dnpc = {alu_res[exu_types_pkg::XLEN-1:1], 1'b0};
            exu_op_pkg::FLOW_BEQ:  dnpc = (alu_res == '0) ? exec_q.target : snpc;
            exu_op_pkg::FLOW_BNE:  dnpc = (alu_res != '0) ? exec_q.target : snpc;
            exu_op_pkg::FLOW_BLT,
            exu_op_pkg::FLOW_BLTU: dnpc = alu_res[0] ? exec_q.target : snpc;
            exu_op_pkg::FLOW_BGE,
            exu_op_pkg::FLOW_BGEU: dnpc = alu_res[0] ? snpc : exec_q.target;
            default:               dnpc = snpc;
        endcase
    end

    // write-back into the register file, same cycle
    assign wb_en   = exec_q.valid && exec_q.wen;
    assign wb_rd   = exec_q.rd;
    assign wb_data = wdata;

    // result strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_wen   <= 1'b0;
        end else begin
            out_valid <= exec_q.valid;
            out_wen   <= wb_en;
        end
    end

    // result payload, qualified by out_valid
    always_ff @(posedge clk) begin
        out_pc   <= exec_q.pc;
        out_dnpc <= dnpc;
        out_rd   <= exec_q.rd;
        out_data <= wdata;
    end

endmodule

//--- hw/exu_core.sv
`timescale 1ns/1ps

module exu_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  exu_op_pkg::exu_op_t     in_op,
    input  logic                    in_use_imm,
    input  exu_types_pkg::reg_idx_t in_rd,
    input  exu_types_pkg::reg_idx_t in_rs1,
    input  exu_types_pkg::reg_idx_t in_rs2,
    input  exu_types_pkg::xlen_t    in_imm,
    input  exu_types_pkg::pc_t      in_pc,
    output logic                    out_valid,
    output exu_types_pkg::pc_t      out_pc,
    output exu_types_pkg::pc_t      out_dnpc,
    output logic                    out_wen,
    output exu_types_pkg::reg_idx_t out_rd,
    output exu_types_pkg::xlen_t    out_data
);

    // write-back from execute into the register file
    logic                    wb_en;
    exu_types_pkg::reg_idx_t wb_rd;
    exu_types_pkg::xlen_t    wb_data;

    // decode output, then buffered copy for execute
    exu_issue_if fetch_q ();
    exu_issue_if exec_q ();

    exu_operand_fetch i_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_use_imm (in_use_imm),
        .in_rd      (in_rd),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_imm     (in_imm),
        .in_pc      (in_pc),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .fetch_q    (fetch_q.src)
    );

    // one stage between decode and execute
    exu_issue_buffer i_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .fetch_q (fetch_q.dst),
        .exec_q  (exec_q.src)
    );

    exu_execute i_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .exec_q    (exec_q.dst),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .out_dnpc  (out_dnpc),
        .out_wen   (out_wen),
        .out_rd    (out_rd),
        .out_data  (out_data)
    );

endmodule

//--- test/exu_clk_gen.sv
`timescale 1ns/1ps

module exu_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset low for the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- test/exu_core_sva.sv
`timescale 1ns/1ps

module exu_core_sva (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic out_wen
);

    // fixed two-edge latency, one result per issue
    property valid_latency;
        @(posedge clk) disable iff (!rst_n)
            out_valid == $past(in_valid, 2);
    endproperty

    // a register write is always part of a result
    property wen_needs_valid;
        @(posedge clk) disable iff (!rst_n)
            out_wen |-> out_valid;
    endproperty

    // no result while in reset
    property quiet_in_reset;
        @(posedge clk) !rst_n |-> !out_valid;
    endproperty

    a_valid_latency: assert property (valid_latency)
        else $error("out_valid does not follow in_valid by two edges");
    a_wen_needs_valid: assert property (wen_needs_valid)
        else $error("out_wen high without out_valid");
    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("out_valid high during reset");

endmodule

//--- test/exu_core_tb.sv
`timescale 1ns/1ps

module exu_core_tb;

    // expected result of one issued instruction
    typedef struct {
        exu_types_pkg::pc_t      pc;
        exu_types_pkg::pc_t      dnpc;
        logic                    wen;
        exu_types_pkg::reg_idx_t rd;
        exu_types_pkg::xlen_t    data;
        int unsigned             due;
    } exp_t;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    exu_op_pkg::exu_op_t     in_op;
    logic                    in_use_imm;
    exu_types_pkg::reg_idx_t in_rd;
    exu_types_pkg::reg_idx_t in_rs1;
    exu_types_pkg::reg_idx_t in_rs2;
    exu_types_pkg::xlen_t    in_imm;
    exu_types_pkg::pc_t      in_pc;
    logic                    out_valid;
    exu_types_pkg::pc_t      out_pc;
    exu_types_pkg::pc_t      out_dnpc;
    logic                    out_wen;
    exu_types_pkg::reg_idx_t out_rd;
    exu_types_pkg::xlen_t    out_data;

    // reference register file cleared like the DUT's
    exu_types_pkg::xlen_t model_gpr [exu_types_pkg::NUM_GPR];
    // results in flight in issue order
    exp_t                 expq [$];
    integer               seed;
    // rising edges seen by the stimulus process
    int unsigned          cyc;
    int unsigned          val_errs;
    int unsigned          proto_errs;
    logic                 run_ok;

    exu_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exu_core i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_use_imm (in_use_imm),
        .in_rd      (in_rd),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_imm     (in_imm),
        .in_pc      (in_pc),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_dnpc   (out_dnpc),
        .out_wen    (out_wen),
        .out_rd     (out_rd),
        .out_data   (out_data)
    );

    bind exu_core exu_core_sva i_sva (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .out_wen   (out_wen)
    );

    task automatic check_data(input string name, input exu_types_pkg::xlen_t got,
                              input exu_types_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_pc(input string name, input exu_types_pkg::pc_t got,
                            input exu_types_pkg::pc_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_rd(input string name, input exu_types_pkg::reg_idx_t got,
                            input exu_types_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_wen(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            val_errs++;
        end
    endtask

    function automatic exu_types_pkg::xlen_t sign_extend_word(input exu_types_pkg::word_t w);
        return {{32{w[31]}}, w};
    endfunction

    // RV64 semantics on the model register file
    function automatic exp_t predict(
        input exu_op_pkg::exu_op_t     op,
        input logic                    use_imm,
        input exu_types_pkg::reg_idx_t rd,
        input exu_types_pkg::reg_idx_t rs1,
        input exu_types_pkg::reg_idx_t rs2,
        input exu_types_pkg::xlen_t    imm,
        input exu_types_pkg::pc_t      pc
    );
        exp_t                 e;
        exu_types_pkg::xlen_t a;
        exu_types_pkg::xlen_t b;
        exu_types_pkg::xlen_t s;
        logic                 taken;
        a = (rs1 == '0) ? '0 : model_gpr[rs1];
        b = (rs2 == '0) ? '0 : model_gpr[rs2];
        // second ALU source from the immediate or from rs2
        s = use_imm ? imm : b;
        e.pc   = pc;
        e.rd   = rd;
        e.data = '0;
        e.due  = 0;
        e.dnpc = pc + exu_op_pkg::PC_STEP;
        taken  = 1'b0;
        case (op)
            exu_op_pkg::OP_ADD:   e.data = a + s;
            exu_op_pkg::OP_SUB:   e.data = a - s;
            exu_op_pkg::OP_SLL:   e.data = a << s[5:0];
            exu_op_pkg::OP_SLT:   e.data = ($signed(a) < $signed(s)) ? 64'd1 : 64'd0;
            exu_op_pkg::OP_SLTU:  e.data = (a < s) ? 64'd1 : 64'd0;
            exu_op_pkg::OP_XOR:   e.data = a ^ s;
            exu_op_pkg::OP_SRL:   e.data = a >> s[5:0];
            exu_op_pkg::OP_SRA:   e.data = $signed(a) >>> s[5:0];
            exu_op_pkg::OP_OR:    e.data = a | s;
            exu_op_pkg::OP_AND:   e.data = a & s;
            // word forms work on the low half with a 5-bit shift amount
            exu_op_pkg::OP_ADDW:  e.data = sign_extend_word(a[31:0] + s[31:0]);
            exu_op_pkg::OP_SUBW:  e.data = sign_extend_word(a[31:0] - s[31:0]);
            exu_op_pkg::OP_SLLW:  e.data = sign_extend_word(a[31:0] << s[4:0]);
            exu_op_pkg::OP_SRLW:  e.data = sign_extend_word(a[31:0] >> s[4:0]);
            exu_op_pkg::OP_SRAW:  e.data = sign_extend_word($signed(a[31:0]) >>> s[4:0]);
            exu_op_pkg::OP_LUI:   e.data = imm;
            exu_op_pkg::OP_AUIPC: e.data = pc + imm;
            exu_op_pkg::OP_JAL: begin
                e.data = pc + exu_op_pkg::PC_STEP;
                e.dnpc = pc + imm;
            end
            exu_op_pkg::OP_JALR: begin
                e.data = pc + exu_op_pkg::PC_STEP;
                e.dnpc = (a + imm) & ~64'd1;
            end
            // branches compare rs1 with rs2 and bltu / bgeu compare unsigned
            exu_op_pkg::OP_BEQ:   taken = (a == b);
            exu_op_pkg::OP_BNE:   taken = (a != b);
            exu_op_pkg::OP_BLT:   taken = ($signed(a) < $signed(b));
            exu_op_pkg::OP_BGE:   taken = ($signed(a) >= $signed(b));
            exu_op_pkg::OP_BLTU:  taken = (a < b);
            default:              taken = (a >= b);
        endcase
        e.wen = !(op inside {exu_op_pkg::OP_BEQ, exu_op_pkg::OP_BNE, exu_op_pkg::OP_BLT,
                             exu_op_pkg::OP_BGE, exu_op_pkg::OP_BLTU, exu_op_pkg::OP_BGEU});
        if (taken) begin
            e.dnpc = pc + imm;
        end
        return e;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        cyc++;
    endtask

    // one cycle of stimulus right after a rising edge
    task automatic issue_random();
        logic [31:0]             r;
        logic [4:0]              code;
        exu_op_pkg::exu_op_t     op;
        logic                    use_imm;
        exu_types_pkg::reg_idx_t rd;
        exu_types_pkg::reg_idx_t rs1;
        exu_types_pkg::reg_idx_t rs2;
        exu_types_pkg::xlen_t    imm;
        exu_types_pkg::pc_t      pc;
        exp_t                    e;
        r = $random(seed);
        // about 70 percent of cycles carry an instruction
        if ((r % 32'd10) >= 32'd7) begin
            in_valid <= 1'b0;
        end else begin
            r       = $random(seed);
            code    = 5'(r % 32'd25);
            op      = exu_op_pkg::exu_op_t'(code);
            use_imm = r[31];
            r    = $random(seed);
            // mostly x0..x7 so results get reused soon
            rd   = r[0] ? r[5:1] : {2'b00, r[8:6]};
            rs1  = r[9] ? r[14:10] : {2'b00, r[17:15]};
            rs2  = r[18] ? r[23:19] : {2'b00, r[26:24]};
            imm  = {$random(seed), $random(seed)};
            if (r[27]) begin
                imm = {{52{imm[11]}}, imm[11:0]};
            end
            pc   = {$random(seed), $random(seed)};
            pc[1:0] = 2'b00;
            in_valid   <= 1'b1;
            in_op      <= op;
            in_use_imm <= use_imm;
            in_rd      <= rd;
            in_rs1     <= rs1;
            in_rs2     <= rs2;
            in_imm     <= imm;
            in_pc      <= pc;
            e = predict(op, use_imm, rd, rs1, rs2, imm, pc);
            // sampled on the next edge and registered out on the one after
            e.due = cyc + 2;
            expq.push_back(e);
            if (e.wen && rd != '0) begin
                model_gpr[rd] = e.data;
            end
        end
    endtask

    task automatic drain_results(output logic ok);
        int unsigned n;
        n = 0;
        while (expq.size() != 0 && n < 10) begin
            next_cycle();
            n++;
        end
        ok = (expq.size() == 0);
        if (!ok) begin
            $display("timeout: %0d results never came out of the DUT", expq.size());
            proto_errs++;
        end
        // a few idle cycles to catch stray results
        for (n = 0; n < 4; n++) begin
            next_cycle();
        end
    endtask

    // scoreboard checks at the falling edge where outputs are stable
    always @(negedge clk) begin
        exp_t e;
        if (rst_n && out_valid) begin
            if (expq.size() == 0) begin
                $display("result at pc 0x%h came out with no instruction in flight", out_pc);
                proto_errs++;
            end else begin
                e = expq.pop_front();
                if (e.due != cyc) begin
                    $display("result for pc 0x%h came out in cycle %0d instead of cycle %0d",
                             e.pc, cyc, e.due);
                    proto_errs++;
                end
                check_pc("out_pc", out_pc, e.pc);
                check_pc("out_dnpc", out_dnpc, e.dnpc);
                check_wen("out_wen", out_wen, e.wen);
                check_rd("out_rd", out_rd, e.rd);
                if (e.wen) begin
                    check_data("out_data", out_data, e.data);
                end
            end
        end
    end

    initial begin
        int unsigned n;
        seed       = 32'h9c05;
        cyc        = 0;
        val_errs   = 0;
        proto_errs = 0;
        run_ok     = 1'b1;
        model_gpr  = '{default: '0};
        in_valid   = 1'b0;
        in_op      = exu_op_pkg::OP_ADD;
        in_use_imm = 1'b0;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        in_imm     = '0;
        in_pc      = '0;
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            next_cycle();
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            proto_errs++;
            run_ok = 1'b0;
        end else begin
            for (n = 0; n < 400; n++) begin
                next_cycle();
                issue_random();
            end
            next_cycle();
            in_valid <= 1'b0;
            drain_results(run_ok);
        end
        $display("errors: %0d value mismatches, %0d protocol errors", val_errs, proto_errs);
        if (run_ok && val_errs == 0 && proto_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- exu_core.f
hw/exu_types_pkg.sv
hw/exu_op_pkg.sv
hw/exu_issue_if.sv
hw/exu_operand_fetch.sv
hw/exu_issue_buffer.sv
hw/exu_execute.sv
hw/exu_core.sv
test/exu_clk_gen.sv
test/exu_core_sva.sv
test/exu_core_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := exu_core_tb
FILELIST  := exu_core.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit status of the model
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
